/* design/vixen_consts.svh */
`ifndef VIXEN_CONSTS_SVH
`define VIXEN_CONSTS_SVH

// datapath and address width
`define VIXEN_W         16

// register file shape
`define VIXEN_NREG      16
`define VIXEN_RW        4

`define VIXEN_PC_IDX    15  // r15 is the program counter
`define VIXEN_LR_IDX    14  // r14 gets the return address on bl

// first fetch after reset
`define VIXEN_RESET_PC  16'h0000

// fixed encodings inside the pr<cond> space
`define VIXEN_OP_NOP    16'h3FEF
`define VIXEN_OP_HLT    16'h3FFF

`endif

/* design/vixen_pkg.sv */
package vixen_pkg;

    // fetch/execute sequencer
    typedef enum logic [2:0] {
        ST_FETCH,
        ST_FETCH2,
        ST_EXECUTE,
        ST_LOAD,
        ST_LOAD2
    } cpu_state_e;

    // what the execute cycle has to commit
    typedef enum logic [3:0] {
        EX_NOP,
        EX_ALU,
        EX_LOAD,
        EX_STORE,
        EX_BRANCH,
        EX_PRED,
        EX_HALT,
        EX_TRAP     // unknown or dropped encoding, behaves like hlt
    } exec_e;

    typedef enum logic [3:0] {
        ALU_MOV,
        ALU_MVN,
        ALU_ADD,
        ALU_ADC,
        ALU_SUB,
        ALU_SBC,
        ALU_AND,
        ALU_ORR,
        ALU_EOR,
        ALU_BIC,
        ALU_CMP,
        ALU_TST,
        ALU_LSL,
        ALU_LSR
    } alu_op_e;

endpackage

/* design/vixen_regs.sv */
`include "vixen_consts.svh"

module vixen_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`VIXEN_RW-1:0] rd_dst_idx,
    input  logic [`VIXEN_RW-1:0] rd_src_idx,
    input  logic [`VIXEN_RW-1:0] rd_base_idx,
    input  logic [`VIXEN_RW-1:0] rd_tgt_idx,
    output logic [`VIXEN_W-1:0]  rd_dst,
    output logic [`VIXEN_W-1:0]  rd_src,
    output logic [`VIXEN_W-1:0]  rd_base,
    output logic [`VIXEN_W-1:0]  rd_tgt,
    output logic [`VIXEN_W-1:0]  pc,
    input  logic                 wr_en,
    input  logic [`VIXEN_RW-1:0] wr_idx,
    input  logic [`VIXEN_W-1:0]  wr_data,
    input  logic                 pc_wr_en,
    input  logic [`VIXEN_W-1:0]  pc_wr_data,
    input  logic                 lr_wr_en,
    input  logic [`VIXEN_W-1:0]  lr_wr_data,
    input  logic                 flag_nz_wr,
    input  logic                 flag_c_wr,
    input  logic                 flag_v_wr,
    input  logic                 flag_n_in,
    input  logic                 flag_z_in,
    input  logic                 flag_c_in,
    input  logic                 flag_v_in,
    output logic                 flag_n,
    output logic                 flag_z,
    output logic                 flag_c,
    output logic                 flag_v
);
    logic [`VIXEN_W-1:0] r [`VIXEN_NREG];

    assign rd_dst  = r[rd_dst_idx];
    assign rd_src  = r[rd_src_idx];
    assign rd_base = r[rd_base_idx];
    assign rd_tgt  = r[rd_tgt_idx];
    assign pc      = {r[`VIXEN_PC_IDX][`VIXEN_W-1:1], 1'b0};   // always halfword aligned

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `VIXEN_NREG; i++) begin
                r[i] <= '0;
            end
            r[`VIXEN_PC_IDX] <= `VIXEN_RESET_PC;
            flag_n <= 1'b0;
            flag_z <= 1'b0;
            flag_c <= 1'b0;
            flag_v <= 1'b0;
        end else begin
            if (pc_wr_en)
                r[`VIXEN_PC_IDX] <= pc_wr_data;
            if (lr_wr_en)
                r[`VIXEN_LR_IDX] <= lr_wr_data;
            // last assignment wins, so a result aimed at r15 beats the increment
            if (wr_en)
                r[wr_idx] <= wr_data;
            if (flag_nz_wr) begin
                flag_n <= flag_n_in;
                flag_z <= flag_z_in;
            end
            if (flag_c_wr)
                flag_c <= flag_c_in;
            if (flag_v_wr)
                flag_v <= flag_v_in;
        end
    end

endmodule

/* design/vixen_alu.sv */
`include "vixen_consts.svh"

module vixen_alu (
    input  vixen_pkg::alu_op_e  alu_op,
    input  logic [`VIXEN_W-1:0] a,
    input  logic [`VIXEN_W-1:0] b,
    input  logic                carry_in,
    output logic [`VIXEN_W-1:0] result,
    output logic                n,
    output logic                z,
    output logic                c,
    output logic                v
);
    logic                is_sub;
    logic                cin;
    logic [`VIXEN_W-1:0] b_add;
    logic [`VIXEN_W:0]   sum;     // 17 bits, top bit is the carry

    always_comb begin
        is_sub = alu_op inside {vixen_pkg::ALU_SUB, vixen_pkg::ALU_SBC, vixen_pkg::ALU_CMP};
        b_add  = is_sub ? ~b : b;
        case (alu_op)
            vixen_pkg::ALU_ADC, vixen_pkg::ALU_SBC: cin = carry_in;
            vixen_pkg::ALU_SUB, vixen_pkg::ALU_CMP: cin = 1'b1;   // two's complement
            default:                                cin = 1'b0;
        endcase
    end

    assign sum = {1'b0, a} + {1'b0, b_add} + {{`VIXEN_W{1'b0}}, cin};

    always_comb begin
        result = sum[`VIXEN_W-1:0];
        c      = sum[`VIXEN_W];
        case (alu_op)
            vixen_pkg::ALU_MOV:                     result = b;
            vixen_pkg::ALU_MVN:                     result = ~b;
            vixen_pkg::ALU_AND, vixen_pkg::ALU_TST: result = a & b;
            vixen_pkg::ALU_ORR:                     result = a | b;
            vixen_pkg::ALU_EOR:                     result = a ^ b;
            vixen_pkg::ALU_BIC:                     result = a & ~b;
            // carry is the last bit out, zero shift leaves it 0
            vixen_pkg::ALU_LSL: {c, result} = {1'b0, a} << b[3:0];
            vixen_pkg::ALU_LSR: {result, c} = {a, 1'b0} >> b[3:0];
            default: ;
        endcase
    end

    assign n = result[`VIXEN_W-1];
    assign z = result == '0;
    // overflow from sign of result, sign mismatch of operands and carry
    assign v = n ^ (a[`VIXEN_W-1] ^ b[`VIXEN_W-1]) ^ c ^ is_sub;

endmodule

/* design/vixen_decode.sv */
`include "vixen_consts.svh"

module vixen_decode (
    input  logic [`VIXEN_W-1:0] op,
    input  logic [`VIXEN_W-1:0] r_src,
    input  logic [`VIXEN_W-1:0] r_base,
    input  logic [`VIXEN_W-1:0] pc,
    input  logic                flag_n,
    input  logic                flag_z,
    input  logic                flag_c,
    input  logic                flag_v,
    output vixen_pkg::exec_e    exec_class,
    output vixen_pkg::alu_op_e  alu_op,
    output logic [`VIXEN_W-1:0] b_val,
    output logic                wr_nz,
    output logic                wr_c,
    output logic                wr_v,
    output logic                reg_wr,
    output logic                wr_pc,
    output logic [`VIXEN_W-1:0] ld_st_addr,
    output logic                ld_st_wide,
    output logic [`VIXEN_W-1:0] br_addr,
    output logic                br_link,
    output logic                pred_true
);
    logic [`VIXEN_RW-1:0] dst;
    logic [3:0]           cond;
    logic [7:0]           num8;
    logic [11:0]          br_off;

    assign dst    = op[3:0];
    assign cond   = op[7:4];
    assign num8   = op[11:4];
    assign br_off = op[11:0];

    // address generation does not depend on the class
    assign ld_st_addr = r_base + {{(`VIXEN_W-5){1'b0}}, op[12:8]};
    assign ld_st_wide = op[13];
    assign br_addr    = pc + {{3{br_off[11]}}, br_off, 1'b0};
    assign br_link    = op[12];         // 1111 is bl, 1110 is b
    assign wr_pc      = reg_wr && dst == `VIXEN_PC_IDX;

    always_comb begin
        exec_class = vixen_pkg::EX_TRAP;
        alu_op     = vixen_pkg::ALU_MOV;
        b_val      = r_src;
        pred_true  = 1'b1;
        case (op[15:14])
            2'b00: begin
                if (!op[13]) begin
                    exec_class = vixen_pkg::EX_ALU;
                    case (op[12:8])
                        5'b00000: alu_op = vixen_pkg::ALU_MOV;
                        5'b00001: alu_op = vixen_pkg::ALU_MVN;
                        5'b00010: alu_op = vixen_pkg::ALU_ADC;
                        5'b00011: alu_op = vixen_pkg::ALU_SBC;
                        5'b00100: alu_op = vixen_pkg::ALU_ADD;
                        5'b00101: alu_op = vixen_pkg::ALU_SUB;
                        5'b01100: alu_op = vixen_pkg::ALU_AND;
                        5'b01101: alu_op = vixen_pkg::ALU_CMP;
                        5'b10100: alu_op = vixen_pkg::ALU_ORR;
                        5'b10101: alu_op = vixen_pkg::ALU_EOR;
                        5'b10110: alu_op = vixen_pkg::ALU_BIC;
                        5'b10111: alu_op = vixen_pkg::ALU_TST;
                        5'b11001: alu_op = vixen_pkg::ALU_LSL;
                        5'b11010: alu_op = vixen_pkg::ALU_LSR;
                        default:  exec_class = vixen_pkg::EX_TRAP;
                    endcase
                    if (op[12:8] inside {5'b11001, 5'b11010})
                        b_val = {{(`VIXEN_W-4){1'b0}}, op[7:4]};    // shift amount
                end else if (dst != `VIXEN_PC_IDX) begin
                    // add# with signed 9-bit immediate
                    exec_class = vixen_pkg::EX_ALU;
                    alu_op     = vixen_pkg::ALU_ADD;
                    b_val      = {{(`VIXEN_W-9){op[12]}}, op[12:4]};
                end else if (op == `VIXEN_OP_NOP) begin
                    exec_class = vixen_pkg::EX_NOP;
                end else if (op == `VIXEN_OP_HLT) begin
                    exec_class = vixen_pkg::EX_HALT;
                end else if (op[12:8] == 5'b11111) begin
                    exec_class = vixen_pkg::EX_PRED;
                    case (cond)
                        4'h0:    pred_true = flag_z;
                        4'h1:    pred_true = ~flag_z;
                        4'h2:    pred_true = flag_c;                 // hs
                        4'h3:    pred_true = ~flag_c;                // lo
                        4'h4:    pred_true = flag_n;
                        4'h5:    pred_true = ~flag_n;
                        4'h6:    pred_true = flag_v;
                        4'h7:    pred_true = ~flag_v;
                        4'h8:    pred_true = flag_c & ~flag_z;       // hi
                        4'h9:    pred_true = ~flag_c | flag_z;       // ls
                        4'ha:    pred_true = ~(flag_n ^ flag_v);     // ge
                        4'hb:    pred_true = flag_n ^ flag_v;        // lt
                        4'hc:    pred_true = ~flag_z & ~(flag_n ^ flag_v);
                        default: pred_true = flag_z | (flag_n ^ flag_v);
                    endcase
                end
            end
            2'b01: exec_class = vixen_pkg::EX_LOAD;
            2'b10: exec_class = vixen_pkg::EX_STORE;
            default: begin
                case (op[13:12])
                    2'b00: begin
                        exec_class = vixen_pkg::EX_ALU;
                        b_val      = {8'b0, num8};      // movl
                    end
                    2'b01: begin
                        exec_class = vixen_pkg::EX_ALU;
                        b_val      = {num8, 8'b0};      // movh
                    end
                    default: exec_class = vixen_pkg::EX_BRANCH;
                endcase
            end
        endcase
    end

    // write masks follow from the operation
    always_comb begin
        reg_wr = 1'b0;
        wr_nz  = 1'b0;
        wr_c   = 1'b0;
        wr_v   = 1'b0;
        if (exec_class == vixen_pkg::EX_ALU) begin
            reg_wr = !(alu_op inside {vixen_pkg::ALU_CMP, vixen_pkg::ALU_TST});
            wr_nz  = !(alu_op inside {vixen_pkg::ALU_MOV, vixen_pkg::ALU_MVN});
            wr_v   = alu_op inside {vixen_pkg::ALU_ADD, vixen_pkg::ALU_ADC, vixen_pkg::ALU_SUB,
                                    vixen_pkg::ALU_SBC, vixen_pkg::ALU_CMP};
            wr_c   = wr_v || alu_op inside {vixen_pkg::ALU_LSL, vixen_pkg::ALU_LSR};
        end
    end

endmodule

/* design/vixen_ctrl.sv */
`include "vixen_consts.svh"

module vixen_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  vixen_pkg::exec_e     exec_class,
    input  logic [`VIXEN_W-1:0]  alu_result,
    input  logic                 reg_wr,
    input  logic                 wr_pc,
    input  logic                 wr_nz,
    input  logic                 wr_c,
    input  logic                 wr_v,
    input  logic [`VIXEN_W-1:0]  ld_st_addr,
    input  logic                 ld_st_wide,
    input  logic [`VIXEN_W-1:0]  r_tgt,
    input  logic [`VIXEN_W-1:0]  br_addr,
    input  logic                 br_link,
    input  logic                 pred_true,
    input  logic [`VIXEN_W-1:0]  pc,
    input  logic [`VIXEN_W-1:0]  mem_dout,
    output logic                 wr_en,
    output logic [`VIXEN_RW-1:0] wr_idx,
    output logic [`VIXEN_W-1:0]  wr_data,
    output logic                 pc_wr_en,
    output logic [`VIXEN_W-1:0]  pc_wr_data,
    output logic                 lr_wr_en,
    output logic [`VIXEN_W-1:0]  lr_wr_data,
    output logic                 flag_nz_wr,
    output logic                 flag_c_wr,
    output logic                 flag_v_wr,
    output logic [`VIXEN_RW-1:0] rd_tgt_idx,
    output logic                 mem_en,
    output logic                 mem_wr,
    output logic                 mem_wide,
    output logic [`VIXEN_W-1:0]  mem_addr,
    output logic [`VIXEN_W-1:0]  mem_din
);
    vixen_pkg::cpu_state_e state;
    logic                  predicated;  // clear means skip the next instruction
    logic [`VIXEN_RW-1:0]  ld_tgt;
    logic [`VIXEN_W-1:0]   ld_value;
    logic                  alu_commit;
    logic                  br_commit;

    assign rd_tgt_idx = mem_dout[`VIXEN_RW-1:0];
    // byte reads arrive in the high half
    assign ld_value   = mem_wide ? mem_dout : {8'b0, mem_dout[15:8]};

    assign alu_commit = state == vixen_pkg::ST_EXECUTE && exec_class == vixen_pkg::EX_ALU;
    assign br_commit  = state == vixen_pkg::ST_EXECUTE && exec_class == vixen_pkg::EX_BRANCH;

    assign wr_en      = (alu_commit && reg_wr) || state == vixen_pkg::ST_LOAD2;
    assign wr_idx     = state == vixen_pkg::ST_LOAD2 ? ld_tgt : mem_dout[`VIXEN_RW-1:0];
    assign wr_data    = state == vixen_pkg::ST_LOAD2 ? ld_value : alu_result;
    assign pc_wr_en   = state == vixen_pkg::ST_FETCH2 || br_commit;
    assign pc_wr_data = state == vixen_pkg::ST_FETCH2 ? pc + 16'd2 : br_addr;
    assign lr_wr_en   = br_commit && br_link;
    assign lr_wr_data = pc;         // already points past the bl
    assign flag_nz_wr = alu_commit && wr_nz;
    assign flag_c_wr  = alu_commit && wr_c;
    assign flag_v_wr  = alu_commit && wr_v;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= vixen_pkg::ST_FETCH;
            predicated <= 1'b1;
            mem_en     <= 1'b0;
            mem_wr     <= 1'b0;
            mem_wide   <= 1'b0;
            mem_addr   <= `VIXEN_RESET_PC;
        end else begin
            case (state)
                vixen_pkg::ST_FETCH: begin
                    mem_addr <= pc;
                    mem_wr   <= 1'b0;
                    mem_wide <= 1'b1;
                    mem_en   <= 1'b1;
                    state    <= vixen_pkg::ST_FETCH2;
                end
                vixen_pkg::ST_FETCH2: begin
                    mem_en     <= 1'b0;
                    predicated <= 1'b1;
                    state      <= predicated ? vixen_pkg::ST_EXECUTE : vixen_pkg::ST_FETCH;
                end
                vixen_pkg::ST_EXECUTE: begin
                    // most classes overlap the next fetch with the commit
                    mem_addr <= pc;
                    mem_wr   <= 1'b0;
                    mem_wide <= 1'b1;
                    mem_en   <= 1'b1;
                    state    <= vixen_pkg::ST_FETCH2;
                    case (exec_class)
                        vixen_pkg::EX_NOP: ;
                        vixen_pkg::EX_ALU: begin
                            if (wr_pc)
                                mem_addr <= alu_result;
                        end
                        vixen_pkg::EX_BRANCH: mem_addr <= br_addr;
                        vixen_pkg::EX_PRED:   predicated <= pred_true;
                        vixen_pkg::EX_LOAD: begin
                            ld_tgt   <= mem_dout[`VIXEN_RW-1:0];
                            mem_addr <= ld_st_addr;
                            mem_wide <= ld_st_wide;
                            state    <= vixen_pkg::ST_LOAD;
                        end
                        vixen_pkg::EX_STORE: begin
                            mem_din  <= r_tgt;
                            mem_addr <= ld_st_addr;
                            mem_wr   <= 1'b1;
                            mem_wide <= ld_st_wide;
                            state    <= vixen_pkg::ST_FETCH;
                        end
                        default: begin      // hlt and trap spin here
                            mem_en <= 1'b0;
                            state  <= vixen_pkg::ST_EXECUTE;
                        end
                    endcase
                end
                vixen_pkg::ST_LOAD: begin
                    mem_en <= 1'b0;
                    state  <= vixen_pkg::ST_LOAD2;
                end
                vixen_pkg::ST_LOAD2: begin
                    mem_addr <= ld_tgt == `VIXEN_PC_IDX ? ld_value : pc;
                    mem_wr   <= 1'b0;
                    mem_wide <= 1'b1;
                    mem_en   <= 1'b1;
                    state    <= vixen_pkg::ST_FETCH2;
                end
                default: state <= vixen_pkg::ST_FETCH;
            endcase
        end
    end

endmodule

/* design/vixen_top.sv */
`include "vixen_consts.svh"

module vixen_top (
    input  logic                clk,
    input  logic                rst_n,
    output logic                mem_en,
    output logic                mem_wr,
    output logic                mem_wide,
    output logic [`VIXEN_W-1:0] mem_addr,
    output logic [`VIXEN_W-1:0] mem_din,
    input  logic [`VIXEN_W-1:0] mem_dout
);
    logic [`VIXEN_W-1:0]  rd_dst, rd_src, rd_base, rd_tgt, pc;
    logic                 flag_n, flag_z, flag_c, flag_v;
    logic                 alu_n, alu_z, alu_c, alu_v;
    logic [`VIXEN_W-1:0]  alu_result, b_val, ld_st_addr, br_addr;
    vixen_pkg::exec_e     exec_class;
    vixen_pkg::alu_op_e   alu_op;
    logic                 wr_nz, wr_c, wr_v, reg_wr, wr_pc;
    logic                 ld_st_wide, br_link, pred_true;
    logic                 wr_en, pc_wr_en, lr_wr_en;
    logic                 flag_nz_wr, flag_c_wr, flag_v_wr;
    logic [`VIXEN_RW-1:0] wr_idx, rd_tgt_idx;
    logic [`VIXEN_W-1:0]  wr_data, pc_wr_data, lr_wr_data;

    // operand fields come straight from the held instruction
    vixen_regs u_regs (
        .clk, .rst_n,
        .rd_dst_idx (mem_dout[3:0]),
        .rd_src_idx (mem_dout[7:4]),
        .rd_base_idx(mem_dout[7:4]),
        .rd_tgt_idx,
        .rd_dst, .rd_src, .rd_base, .rd_tgt, .pc,
        .wr_en, .wr_idx, .wr_data,
        .pc_wr_en, .pc_wr_data, .lr_wr_en, .lr_wr_data,
        .flag_nz_wr, .flag_c_wr, .flag_v_wr,
        .flag_n_in(alu_n), .flag_z_in(alu_z), .flag_c_in(alu_c), .flag_v_in(alu_v),
        .flag_n, .flag_z, .flag_c, .flag_v
    );

    vixen_decode u_decode (
        .op(mem_dout), .r_src(rd_src), .r_base(rd_base), .pc,
        .flag_n, .flag_z, .flag_c, .flag_v,
        .exec_class, .alu_op, .b_val,
        .wr_nz, .wr_c, .wr_v, .reg_wr, .wr_pc,
        .ld_st_addr, .ld_st_wide, .br_addr, .br_link, .pred_true
    );

    vixen_alu u_alu (
        .alu_op, .a(rd_dst), .b(b_val), .carry_in(flag_c),
        .result(alu_result), .n(alu_n), .z(alu_z), .c(alu_c), .v(alu_v)
    );

    vixen_ctrl u_ctrl (
        .clk, .rst_n,
        .exec_class, .alu_result,
        .reg_wr, .wr_pc, .wr_nz, .wr_c, .wr_v,
        .ld_st_addr, .ld_st_wide, .r_tgt(rd_tgt),
        .br_addr, .br_link, .pred_true, .pc, .mem_dout,
        .wr_en, .wr_idx, .wr_data,
        .pc_wr_en, .pc_wr_data, .lr_wr_en, .lr_wr_data,
        .flag_nz_wr, .flag_c_wr, .flag_v_wr,
        .rd_tgt_idx,
        .mem_en, .mem_wr, .mem_wide, .mem_addr, .mem_din
    );

endmodule

/* sim/tb_mem.sv */
module tb_mem (
    input  logic        clk,
    input  logic        mem_en,
    input  logic        mem_wr,
    input  logic        mem_wide,
    input  logic [15:0] mem_addr,
    input  logic [15:0] mem_din,
    output logic [15:0] mem_dout
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] mem [0:65535];    // byte addressed, big endian words

    initial begin
        mem_dout = '0;
    end

    // one access per strobe, read data shows up in the next cycle
    always @(posedge clk) begin
        logic [15:0] rd_word;
        if (mem_en && mem_wr) begin
            if (mem_wide) begin
                mem[mem_addr] = mem_din[15:8];
                mem[mem_addr + 16'd1] = mem_din[7:0];
            end else begin
                mem[mem_addr] = mem_din[7:0];   // low byte only
            end
        end else if (mem_en) begin
            if (mem_wide)
                rd_word = {mem[mem_addr], mem[mem_addr + 16'd1]};
            else
                rd_word = {mem[mem_addr], 8'h00};
            #5;
            mem_dout = rd_word;     // held until the next read
        end
    end

endmodule

/* sim/tb_vixen.sv */
module tb_vixen;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [4:0] op_mov = 5'h00;
    localparam logic [4:0] op_mvn = 5'h01;
    localparam logic [4:0] op_adc = 5'h02;
    localparam logic [4:0] op_sbc = 5'h03;
    localparam logic [4:0] op_add = 5'h04;
    localparam logic [4:0] op_sub = 5'h05;
    localparam logic [4:0] op_and = 5'h0C;
    localparam logic [4:0] op_cmp = 5'h0D;
    localparam logic [4:0] op_orr = 5'h14;
    localparam logic [4:0] op_eor = 5'h15;
    localparam logic [4:0] op_bic = 5'h16;
    localparam logic [4:0] op_tst = 5'h17;
    localparam logic [4:0] op_lsl = 5'h19;
    localparam logic [4:0] op_lsr = 5'h1A;

    logic        clk;
    logic        rst_n;
    logic        mem_en;
    logic        mem_wr;
    logic        mem_wide;
    logic [15:0] mem_addr;
    logic [15:0] mem_din;
    logic [15:0] mem_dout;

    logic [15:0] prog [$];      // instruction words from address 0
    logic [15:0] exp_addr [$];
    logic [15:0] exp_data [$];
    logic        exp_wide [$];
    int          n_stores;
    int          low_cycles;

    vixen_top dut (
        .clk(clk), .rst_n(rst_n),
        .mem_en(mem_en), .mem_wr(mem_wr), .mem_wide(mem_wide),
        .mem_addr(mem_addr), .mem_din(mem_din), .mem_dout(mem_dout)
    );

    tb_mem u_mem (
        .clk(clk),
        .mem_en(mem_en), .mem_wr(mem_wr), .mem_wide(mem_wide),
        .mem_addr(mem_addr), .mem_din(mem_din), .mem_dout(mem_dout)
    );

    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

    // instruction encoders
    function automatic logic [15:0] alu_rr(logic [4:0] opc, logic [3:0] src, logic [3:0] dst);
        return {3'b000, opc, src, dst};
    endfunction

    function automatic logic [15:0] add_imm(logic [8:0] imm, logic [3:0] dst);
        return {3'b001, imm, dst};
    endfunction

    function automatic logic [15:0] ld_st(logic st, logic wide, logic [4:0] off,
                                          logic [3:0] base, logic [3:0] tgt);
        return {st ? 2'b10 : 2'b01, wide, off, base, tgt};
    endfunction

    function automatic logic [15:0] mov_lo(logic [7:0] imm, logic [3:0] dst);
        return {4'hC, imm, dst};
    endfunction

    function automatic logic [15:0] mov_hi(logic [7:0] imm, logic [3:0] dst);
        return {4'hD, imm, dst};
    endfunction

    function automatic logic [15:0] branch_op(logic link, logic [11:0] off);
        return {3'b111, link, off};
    endfunction

    function automatic logic [15:0] pred_op(logic [3:0] cond);
        return {8'h3F, cond, 4'hF};
    endfunction

    task automatic emit(logic [15:0] word);
        prog.push_back(word);
    endtask

    task automatic expect_store(logic [15:0] addr, logic [15:0] data, logic wide);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        exp_wide.push_back(wide);
    endtask

    // pr<cond> guarding a word store of r8 (0x005a)
    task automatic pred_then_store(logic [3:0] cond, logic taken, logic [3:0] base,
                                   logic [15:0] base_addr, logic [4:0] off);
        emit(pred_op(cond));
        emit(ld_st(1'b1, 1'b1, off, base, 4'd8));
        if (taken)
            expect_store(base_addr + 16'(off), 16'h005A, 1'b1);
    endtask

    task automatic build_program();
        logic [13:0] taken_a;
        int          bl_at;
        taken_a = 14'b10101010011010;   // n=1 z=0 c=0 v=0
        // register alu ops with r13 as the store base 0x0100
        emit(mov_hi(8'h01, 4'd13));
        emit(mov_hi(8'h12, 4'd1));
        emit(mov_lo(8'h34, 4'd2));
        emit(alu_rr(op_orr, 4'd2, 4'd1));
        emit(ld_st(1'b1, 1'b1, 5'd0, 4'd13, 4'd1));
        expect_store(16'h0100, 16'h1234, 1'b1);
        emit(mov_lo(8'hF0, 4'd3));
        emit(alu_rr(op_mov, 4'd1, 4'd4));
        emit(alu_rr(op_add, 4'd3, 4'd4));
        emit(ld_st(1'b1, 1'b1, 5'd2, 4'd13, 4'd4));
        expect_store(16'h0102, 16'h1324, 1'b1);
        emit(alu_rr(op_mov, 4'd1, 4'd5));
        emit(alu_rr(op_sub, 4'd3, 4'd5));
        emit(ld_st(1'b1, 1'b1, 5'd4, 4'd13, 4'd5));
        expect_store(16'h0104, 16'h1144, 1'b1);
        emit(alu_rr(op_mov, 4'd1, 4'd6));
        emit(alu_rr(op_and, 4'd3, 4'd6));
        emit(ld_st(1'b1, 1'b1, 5'd6, 4'd13, 4'd6));
        expect_store(16'h0106, 16'h0030, 1'b1);
        emit(alu_rr(op_mov, 4'd1, 4'd7));
        emit(alu_rr(op_eor, 4'd3, 4'd7));
        emit(ld_st(1'b1, 1'b1, 5'd8, 4'd13, 4'd7));
        expect_store(16'h0108, 16'h12C4, 1'b1);
        emit(alu_rr(op_mov, 4'd1, 4'd8));
        emit(alu_rr(op_bic, 4'd3, 4'd8));
        emit(ld_st(1'b1, 1'b1, 5'd10, 4'd13, 4'd8));
        expect_store(16'h010A, 16'h1204, 1'b1);
        emit(alu_rr(op_mvn, 4'd1, 4'd9));
        emit(ld_st(1'b1, 1'b1, 5'd12, 4'd13, 4'd9));
        expect_store(16'h010C, 16'hEDCB, 1'b1);
        emit(alu_rr(op_mov, 4'd1, 4'd10));
        emit(alu_rr(op_lsl, 4'd4, 4'd10));     // shift amount in the src field
        emit(ld_st(1'b1, 1'b1, 5'd14, 4'd13, 4'd10));
        expect_store(16'h010E, 16'h2340, 1'b1);
        emit(alu_rr(op_mov, 4'd1, 4'd11));
        emit(alu_rr(op_lsr, 4'd4, 4'd11));
        emit(ld_st(1'b1, 1'b1, 5'd16, 4'd13, 4'd11));
        expect_store(16'h0110, 16'h0123, 1'b1);
        // add# with negative immediates and a carry chain
        emit(mov_lo(8'h10, 4'd2));
        emit(add_imm(9'h1FD, 4'd2));           // -3
        emit(ld_st(1'b1, 1'b1, 5'd18, 4'd13, 4'd2));
        expect_store(16'h0112, 16'h000D, 1'b1);
        emit(mov_lo(8'h05, 4'd3));
        emit(mov_lo(8'h20, 4'd4));
        emit(mov_lo(8'h20, 4'd5));
        emit(mov_lo(8'h40, 4'd6));
        emit(alu_rr(op_cmp, 4'd2, 4'd3));      // 5 - 13 borrows so c=0
        emit(alu_rr(op_adc, 4'd3, 4'd4));      // 0x20 + 5 + 0
        emit(alu_rr(op_cmp, 4'd3, 4'd2));      // 13 - 5 sets c=1
        emit(alu_rr(op_sbc, 4'd3, 4'd5));      // 0x20 + ~5 + 1
        emit(alu_rr(op_adc, 4'd3, 4'd6));      // 0x40 + 5 + 1
        emit(ld_st(1'b1, 1'b1, 5'd20, 4'd13, 4'd4));
        expect_store(16'h0114, 16'h0025, 1'b1);
        emit(ld_st(1'b1, 1'b1, 5'd22, 4'd13, 4'd5));
        expect_store(16'h0116, 16'h001B, 1'b1);
        emit(ld_st(1'b1, 1'b1, 5'd24, 4'd13, 4'd6));
        expect_store(16'h0118, 16'h0046, 1'b1);
        emit(mov_lo(8'h02, 4'd7));
        emit(add_imm(9'h1FB, 4'd7));           // -5
        emit(ld_st(1'b1, 1'b1, 5'd26, 4'd13, 4'd7));
        expect_store(16'h011A, 16'hFFFD, 1'b1);
        // loads from the data bytes at 0x0200
        emit(mov_hi(8'h02, 4'd12));
        emit(ld_st(1'b0, 1'b0, 5'd1, 4'd12, 4'd1));
        emit(ld_st(1'b0, 1'b1, 5'd2, 4'd12, 4'd2));
        emit(ld_st(1'b0, 1'b0, 5'd0, 4'd12, 4'd3));
        emit(ld_st(1'b1, 1'b0, 5'd28, 4'd13, 4'd1));
        expect_store(16'h011C, 16'h003C, 1'b0);
        emit(ld_st(1'b1, 1'b1, 5'd30, 4'd13, 4'd2));
        expect_store(16'h011E, 16'h7E81, 1'b1);
        emit(ld_st(1'b1, 1'b1, 5'd0, 4'd13, 4'd3));
        expect_store(16'h0100, 16'h00A5, 1'b1);
        emit(ld_st(1'b1, 1'b0, 5'd1, 4'd13, 4'd2));
        expect_store(16'h0101, 16'h0081, 1'b0);
        emit(ld_st(1'b0, 1'b1, 5'd0, 4'd13, 4'd4));   // byte 0x100 must still be 0
        emit(ld_st(1'b1, 1'b1, 5'd2, 4'd13, 4'd4));
        expect_store(16'h0102, 16'h0081, 1'b1);
        // predication on bases r11=0x0140 and r10=0x0160
        emit(alu_rr(op_mov, 4'd13, 4'd11));
        emit(add_imm(9'h040, 4'd11));
        emit(alu_rr(op_mov, 4'd13, 4'd10));
        emit(add_imm(9'h060, 4'd10));
        emit(mov_lo(8'h5A, 4'd8));
        emit(mov_lo(8'h05, 4'd3));
        emit(mov_lo(8'h0D, 4'd2));
        emit(alu_rr(op_cmp, 4'd2, 4'd3));
        for (int k = 0; k < 14; k++) begin
            pred_then_store(4'(k), taken_a[k], 4'd11, 16'h0140, 5'(2 * k));
        end
        emit(mov_hi(8'h80, 4'd4));
        emit(mov_lo(8'h01, 4'd5));
        emit(alu_rr(op_cmp, 4'd5, 4'd4));      // n=0 z=0 c=1 v=1
        pred_then_store(4'h6, 1'b1, 4'd10, 16'h0160, 5'd0);
        pred_then_store(4'h7, 1'b0, 4'd10, 16'h0160, 5'd2);
        pred_then_store(4'h8, 1'b1, 4'd10, 16'h0160, 5'd4);
        pred_then_store(4'hA, 1'b0, 4'd10, 16'h0160, 5'd6);
        emit(mov_lo(8'hF0, 4'd6));
        emit(mov_lo(8'h0F, 4'd7));
        emit(alu_rr(op_tst, 4'd7, 4'd6));      // z=1 with c and v kept
        pred_then_store(4'h0, 1'b1, 4'd10, 16'h0160, 5'd8);
        pred_then_store(4'h1, 1'b0, 4'd10, 16'h0160, 5'd10);
        pred_then_store(4'h9, 1'b1, 4'd10, 16'h0160, 5'd12);
        pred_then_store(4'hC, 1'b0, 4'd10, 16'h0160, 5'd14);
        // b jumps over two stores
        emit(branch_op(1'b0, 12'd2));
        emit(ld_st(1'b1, 1'b1, 5'd0, 4'd13, 4'd8));
        emit(ld_st(1'b1, 1'b1, 5'd2, 4'd13, 4'd8));
        bl_at = prog.size() * 2;
        emit(branch_op(1'b1, 12'd1));
        emit(ld_st(1'b1, 1'b1, 5'd0, 4'd13, 4'd8));
        emit(ld_st(1'b1, 1'b1, 5'd4, 4'd13, 4'd14));
        expect_store(16'h0104, 16'(bl_at + 2), 1'b1);   // return address
        emit(16'h3FEF);     // nop
        emit(16'h3FFF);     // hlt
        emit(ld_st(1'b1, 1'b1, 5'd6, 4'd13, 4'd8));      // never reached
    endtask

    task automatic load_image();
        for (int i = 0; i < 65536; i++) begin
            u_mem.mem[i] = i[7:0] ^ i[15:8] ^ 8'h5A;
        end
        for (int i = 0; i < prog.size(); i++) begin
            u_mem.mem[2 * i]     = prog[i][15:8];
            u_mem.mem[2 * i + 1] = prog[i][7:0];
        end
        u_mem.mem[16'h0200] = 8'hA5;
        u_mem.mem[16'h0201] = 8'h3C;
        u_mem.mem[16'h0202] = 8'h7E;
        u_mem.mem[16'h0203] = 8'h81;
    endtask

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check(string name, logic [15:0] got, logic [15:0] want);
        if (got !== want)
            abort_run($sformatf("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, want));
    endtask

    // writes are compared in order at mid cycle
    always @(negedge clk) begin
        if (rst_n && mem_en && mem_wr) begin
            if (n_stores >= exp_addr.size()) begin
                abort_run("a store happened after the last expected store");
            end else begin
                check("mem_addr", mem_addr, exp_addr[n_stores]);
                check("mem_wide", {15'b0, mem_wide}, {15'b0, exp_wide[n_stores]});
                if (exp_wide[n_stores])
                    check("mem_din", mem_din, exp_data[n_stores]);
                else
                    check("mem_din[7:0]", {8'h00, mem_din[7:0]}, exp_data[n_stores]);
                n_stores++;
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        n_stores = 0;
        low_cycles = 0;
        build_program();
        load_image();
        repeat (2) @(posedge clk);
        #5 rst_n = 1'b1;
        wait (n_stores == exp_addr.size());
        // halted core keeps the port quiet
        while (low_cycles < 20) begin
            @(negedge clk);
            if (mem_en)
                low_cycles = 0;
            else
                low_cycles++;
        end
        $display("*** PASSED ***");
        $finish;
    end

    initial begin
        int limit;
        @(posedge rst_n);
        limit = 4 * prog.size() + 200;
        repeat (limit) @(posedge clk);
        abort_run($sformatf("timeout: the run did not finish within %0d cycles", limit));
    end

endmodule

/* filelist.f */
+incdir+design
design/vixen_pkg.sv
design/vixen_regs.sv
design/vixen_alu.sv
design/vixen_decode.sv
design/vixen_ctrl.sv
design/vixen_top.sv
sim/tb_mem.sv
sim/tb_vixen.sv

/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_vixen -Mdir obj_dir

run: compile
	./obj_dir/Vtb_vixen | tee sim.log
	grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
